//--- logic/vec_pkg.sv
/*
 * Vector accelerator package
 * Lane count, vector sizes, element and index types, opcodes and the
 * host request and response formats shared by every block
 */

`default_nettype none

package vec_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////

  localparam int NR_LANES       = 4;
  localparam int ELEMS_PER_LANE = 8;
  localparam int VLMAX          = NR_LANES * ELEMS_PER_LANE;
  localparam int NR_VREGS       = 32;
  localparam int ELEN           = 32;

  // Index widths derived from the sizes above
  localparam int LANE_IDX_W = $clog2(NR_LANES);
  localparam int ELEM_IDX_W = $clog2(ELEMS_PER_LANE);
  localparam int VREG_W     = $clog2(NR_VREGS);
  // One extra bit so oversized lengths can arrive and be rejected
  localparam int VL_W       = $clog2(VLMAX) + 1;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  typedef logic [ELEN-1:0]       elen_t;
  typedef logic [VREG_W-1:0]     vreg_t;
  typedef logic [VL_W-1:0]       vl_t;
  typedef logic [ELEM_IDX_W-1:0] lane_elem_t;

  typedef enum logic [2:0] {
    OP_VADD_VV = 3'd0,
    OP_VSUB_VV = 3'd1,
    OP_VXOR_VV = 3'd2,
    OP_VADD_VX = 3'd3,
    OP_VMV_VX  = 3'd4,
    OP_VEXT_XV = 3'd5
  } vec_op_e;

  // Host request, 56 bits
  typedef struct packed {
    vec_op_e op;
    vreg_t   vd;
    vreg_t   vs1;
    vreg_t   vs2;
    // Scalar operand, or element index for an extract
    elen_t   scalar;
    vl_t     vl;
  } acc_req_t;

  // Host response, 33 bits
  typedef struct packed {
    elen_t result;
    logic  error;
  } acc_resp_t;

endpackage

`default_nettype wire

//--- logic/lane_vrf.sv
/*
 * Lane register file slice
 * Holds this lane's elements of every vector register, two
 * combinational read ports and one clocked write port
 */

`timescale 1ns/1ps
`default_nettype none

module lane_vrf (
  input  logic                clk_i,
  input  logic                reset_i,
  input  vec_pkg::vreg_t      rd_a_reg_i,
  input  vec_pkg::vreg_t      rd_b_reg_i,
  input  vec_pkg::lane_elem_t rd_idx_i,
  output vec_pkg::elen_t      rd_a_data_o,
  output vec_pkg::elen_t      rd_b_data_o,
  input  logic                wr_en_i,
  input  vec_pkg::vreg_t      wr_reg_i,
  input  vec_pkg::lane_elem_t wr_idx_i,
  input  vec_pkg::elen_t      wr_data_i
);

  import vec_pkg::*;

  elen_t mem [NR_VREGS][ELEMS_PER_LANE];

  assign rd_a_data_o = mem[rd_a_reg_i][rd_idx_i];
  assign rd_b_data_o = mem[rd_b_reg_i][rd_idx_i];

  // Every register starts at zero
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int r = 0; r < NR_VREGS; r++) begin
        for (int e = 0; e < ELEMS_PER_LANE; e++) begin
          mem[r][e] <= '0;
        end
      end
    end else if (wr_en_i) begin
      mem[wr_reg_i][wr_idx_i] <= wr_data_i;
    end
  end

endmodule

`default_nettype wire

//--- logic/vec_lane.sv
/*
 * Vector lane
 * Processes the local elements of one lane, one per cycle, through an
 * integer datapath and serves extract reads from its register slice
 */

`timescale 1ns/1ps
`default_nettype none

module vec_lane #(
  parameter int unsigned LANE_ID = 0
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              lane_start_i,
  input  vec_pkg::acc_req_t lane_insn_i,
  output logic              lane_done_o,
  output vec_pkg::elen_t    lane_elem_o
);

  import vec_pkg::*;

  logic [VL_W:0] span;
  logic [VL_W:0] n_elems;
  lane_elem_t    last_idx;
  lane_elem_t    cnt_q;
  lane_elem_t    ext_idx;
  logic          writing_q;
  logic          done_q;
  logic          is_ext;
  logic          owns;
  elen_t         rd_a_data;
  elen_t         rd_b_data;
  elen_t         alu_res;

  // Elements below vl whose global index maps to this lane
  assign span     = {1'b0, lane_insn_i.vl} + (VL_W + 1)'(NR_LANES - 1 - LANE_ID);
  assign n_elems  = span >> LANE_IDX_W;
  assign last_idx = lane_elem_t'(n_elems - 1'b1);

  assign is_ext  = lane_insn_i.op == OP_VEXT_XV;
  assign owns    = lane_insn_i.scalar[LANE_IDX_W-1:0] == LANE_IDX_W'(LANE_ID);
  assign ext_idx = lane_insn_i.scalar[LANE_IDX_W +: ELEM_IDX_W];

  //////////////////////////////////////////////////
  // Integer datapath
  //////////////////////////////////////////////////

  always_comb begin
    case (lane_insn_i.op)
      OP_VADD_VV: alu_res = rd_b_data + rd_a_data;
      // vd = vs2 - vs1
      OP_VSUB_VV: alu_res = rd_b_data - rd_a_data;
      OP_VXOR_VV: alu_res = rd_b_data ^ rd_a_data;
      OP_VADD_VX: alu_res = rd_b_data + lane_insn_i.scalar;
      OP_VMV_VX:  alu_res = lane_insn_i.scalar;
      default:    alu_res = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      writing_q <= 1'b0;
      cnt_q     <= '0;
      done_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (lane_start_i) begin
        cnt_q <= '0;
        if (is_ext || n_elems == '0) begin
          done_q <= 1'b1;
        end else begin
          writing_q <= 1'b1;
        end
      end else if (writing_q) begin
        cnt_q <= cnt_q + 1'b1;
        if (cnt_q == last_idx) begin
          writing_q <= 1'b0;
          done_q    <= 1'b1;
        end
      end
    end
  end

  assign lane_done_o = done_q;
  // Non-owning lanes contribute zero
  assign lane_elem_o = (is_ext && owns) ? rd_b_data : '0;

  lane_vrf u_lane_vrf (
    .clk_i       (clk_i                           ),
    .reset_i     (reset_i                         ),
    .rd_a_reg_i  (lane_insn_i.vs1                 ),
    .rd_b_reg_i  (lane_insn_i.vs2                 ),
    .rd_idx_i    (writing_q ? cnt_q : ext_idx     ),
    .rd_a_data_o (rd_a_data                       ),
    .rd_b_data_o (rd_b_data                       ),
    .wr_en_i     (writing_q                       ),
    .wr_reg_i    (lane_insn_i.vd                  ),
    .wr_idx_i    (cnt_q                           ),
    .wr_data_i   (alu_res                         )
  );

endmodule

`default_nettype wire

//--- logic/vec_sequencer.sv
/*
 * Vector sequencer
 * Broadcasts the issued instruction to all lanes, tracks lane completion
 * and returns the extracted element to the dispatcher
 */

`timescale 1ns/1ps
`default_nettype none

module vec_sequencer (
  input  logic                                     clk_i,
  input  logic                                     reset_i,
  // Dispatcher side
  input  logic                                     issue_i,
  input  vec_pkg::acc_req_t                        insn_i,
  output logic                                     done_o,
  output vec_pkg::elen_t                           result_o,
  // Lane side
  output logic                                     lane_start_o,
  output vec_pkg::acc_req_t                        lane_insn_o,
  input  logic           [vec_pkg::NR_LANES-1:0]   lane_done_i,
  input  vec_pkg::elen_t [vec_pkg::NR_LANES-1:0]   lane_elem_i
);

  import vec_pkg::*;

  acc_req_t              insn_q;
  logic                  start_q;
  logic                  busy_q;
  logic                  fin_q;
  logic   [NR_LANES-1:0] seen_q;
  logic   [NR_LANES-1:0] seen_all;
  logic                  last_done;
  elen_t                 result_q;

  assign seen_all  = seen_q | lane_done_i;
  assign last_done = busy_q && (&seen_all);

  assign lane_start_o = start_q;
  // Held for the whole instruction, lanes read it directly
  assign lane_insn_o  = insn_q;
  assign done_o       = fin_q;
  assign result_o     = result_q;

  always_ff @(posedge clk_i) begin
    if (issue_i) begin
      insn_q <= insn_i;
    end
    if (last_done) begin
      // Owning lane is the low bits of the element index
      result_q <= (insn_q.op == OP_VEXT_XV) ?
                  lane_elem_i[insn_q.scalar[LANE_IDX_W-1:0]] : '0;
    end
  end

  // Sticky per-lane done bits
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      start_q <= 1'b0;
      busy_q  <= 1'b0;
      fin_q   <= 1'b0;
      seen_q  <= '0;
    end else begin
      start_q <= issue_i;
      fin_q   <= last_done;
      if (start_q) begin
        busy_q <= 1'b1;
        seen_q <= '0;
      end else if (busy_q) begin
        seen_q <= seen_all;
        if (&seen_all) busy_q <= 1'b0;
      end
    end
  end

  a_single_done : assert property (@(posedge clk_i) disable iff (reset_i)
    (lane_done_i & seen_q) == '0);

endmodule

`default_nettype wire

//--- logic/vec_dispatcher.sv
/*
 * Vector dispatcher
 * Accepts host requests one at a time, rejects oversized vector lengths,
 * issues legal instructions to the sequencer and holds the response
 * until the host takes it
 */

`timescale 1ns/1ps
`default_nettype none

module vec_dispatcher (
  input  logic               clk_i,
  input  logic               reset_i,
  // Host request
  input  vec_pkg::acc_req_t  acc_req_i,
  input  logic               acc_req_valid_i,
  output logic               acc_req_ready_o,
  // Host response
  output vec_pkg::acc_resp_t acc_resp_o,
  output logic               acc_resp_valid_o,
  input  logic               acc_resp_ready_i,
  // Sequencer side
  output logic               issue_o,
  output vec_pkg::acc_req_t  insn_o,
  input  logic               done_i,
  input  vec_pkg::elen_t     result_i
);

  import vec_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_WAIT,
    ST_RESP
  } disp_state_e;

  disp_state_e state_q, state_d;
  acc_req_t    req_q;
  acc_resp_t   resp_q;
  logic        accept;
  logic        vl_bad;

  assign accept = acc_req_valid_i && acc_req_ready_o;
  assign vl_bad = acc_req_i.vl > vl_t'(VLMAX);

  assign acc_req_ready_o  = state_q == ST_IDLE;
  assign acc_resp_valid_o = state_q == ST_RESP;
  assign acc_resp_o       = resp_q;
  assign issue_o          = state_q == ST_ISSUE;
  assign insn_o           = req_q;

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:  if (accept) state_d = vl_bad ? ST_RESP : ST_ISSUE;
      ST_ISSUE: state_d = ST_WAIT;
      ST_WAIT:  if (done_i) state_d = ST_RESP;
      ST_RESP:  if (acc_resp_ready_i) state_d = ST_IDLE;
      default:  state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request and response payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= acc_req_i;
    end
    if (accept && vl_bad) begin
      resp_q.result <= '0;
      resp_q.error  <= 1'b1;
    end else if (done_i) begin
      resp_q.result <= result_i;
      resp_q.error  <= 1'b0;
    end
  end

  // Sequencer must only complete an instruction that was issued
  a_done_in_wait : assert property (@(posedge clk_i) disable iff (reset_i)
    done_i |-> state_q == ST_WAIT);

endmodule

`default_nettype wire

//--- logic/vec_top.sv
/*
 * Vector accelerator top level
 * Dispatcher, sequencer and the array of lanes
 */

`timescale 1ns/1ps
`default_nettype none

module vec_top (
  input  logic               clk_i,
  input  logic               reset_i,
  input  vec_pkg::acc_req_t  acc_req_i,
  input  logic               acc_req_valid_i,
  output logic               acc_req_ready_o,
  output vec_pkg::acc_resp_t acc_resp_o,
  output logic               acc_resp_valid_o,
  input  logic               acc_resp_ready_i
);

  import vec_pkg::*;

  logic                  issue;
  acc_req_t              insn;
  logic                  done;
  elen_t                 result;
  logic                  lane_start;
  acc_req_t              lane_insn;
  logic   [NR_LANES-1:0] lane_done;
  elen_t  [NR_LANES-1:0] lane_elem;

  vec_dispatcher u_dispatcher (
    .clk_i            (clk_i           ),
    .reset_i          (reset_i         ),
    .acc_req_i        (acc_req_i       ),
    .acc_req_valid_i  (acc_req_valid_i ),
    .acc_req_ready_o  (acc_req_ready_o ),
    .acc_resp_o       (acc_resp_o      ),
    .acc_resp_valid_o (acc_resp_valid_o),
    .acc_resp_ready_i (acc_resp_ready_i),
    .issue_o          (issue           ),
    .insn_o           (insn            ),
    .done_i           (done            ),
    .result_i         (result          )
  );

  vec_sequencer u_sequencer (
    .clk_i        (clk_i     ),
    .reset_i      (reset_i   ),
    .issue_i      (issue     ),
    .insn_i       (insn      ),
    .done_o       (done      ),
    .result_o     (result    ),
    .lane_start_o (lane_start),
    .lane_insn_o  (lane_insn ),
    .lane_done_i  (lane_done ),
    .lane_elem_i  (lane_elem )
  );

  //////////////////////////////////////////////////
  // Lanes
  //////////////////////////////////////////////////

  for (genvar i = 0; i < NR_LANES; i++) begin : gen_lanes
    vec_lane #(
      .LANE_ID (i)
    ) u_lane (
      .clk_i        (clk_i       ),
      .reset_i      (reset_i     ),
      .lane_start_i (lane_start  ),
      .lane_insn_i  (lane_insn   ),
      .lane_done_o  (lane_done[i]),
      .lane_elem_o  (lane_elem[i])
    );
  end

  // Element to lane mapping relies on a power-of-two lane count
  if (NR_LANES == 0) begin : gen_chk_zero
    $error("vec_top needs at least one lane");
  end
  if (NR_LANES != 2 ** $clog2(NR_LANES)) begin : gen_chk_pow2
    $error("vec_top lane count must be a power of two");
  end

endmodule

`default_nettype wire

//--- tb/tb_vec_top.sv
/*
 * Testbench for the vector accelerator top level
 * Random vector instructions from a fixed seed, checked against a
 * register file model held in the testbench
 */

`timescale 1ns/1ps
`default_nettype none

module tb_vec_top;

  import vec_pkg::*;

  // Instructions per test section
  localparam int N_RESET_EXT = 8;
  localparam int N_STREAM    = 12;
  localparam int N_BAD_VL    = 4;
  localparam int N_STALL     = 40;
  localparam int N_INSNS     = N_RESET_EXT + (2 + VLMAX) + N_STREAM * (1 + VLMAX) +
                               N_BAD_VL * (1 + VLMAX) + N_STALL;
  localparam int TIMEOUT     = N_INSNS * 40;

  logic      clk_i;
  logic      reset_i;
  acc_req_t  acc_req_i;
  logic      acc_req_valid_i;
  logic      acc_req_ready_o;
  acc_resp_t acc_resp_o;
  logic      acc_resp_valid_o;
  logic      acc_resp_ready_i;

  integer seed;
  int     cycles = 0;
  elen_t  model [NR_VREGS][VLMAX];

  vec_top u_vec_top (
    .clk_i            (clk_i           ),
    .reset_i          (reset_i         ),
    .acc_req_i        (acc_req_i       ),
    .acc_req_valid_i  (acc_req_valid_i ),
    .acc_req_ready_o  (acc_req_ready_o ),
    .acc_resp_o       (acc_resp_o      ),
    .acc_resp_valid_o (acc_resp_valid_o),
    .acc_resp_ready_i (acc_resp_ready_i)
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT) begin
      fail_run($sformatf("Timeout, the run did not finish within %0d cycles", TIMEOUT));
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "Stopped at the first failure");
  endtask

  task automatic check_result(input string name, input elen_t got, input elen_t exp);
    if (got !== exp) begin
      fail_run($sformatf("ERROR %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic check_error(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  function automatic vreg_t rand_reg();
    // Small register pool so instructions reuse earlier results
    return vreg_t'({$random(seed)} % 8);
  endfunction

  function automatic vl_t rand_vl();
    return vl_t'({$random(seed)} % (VLMAX + 1));
  endfunction

  function automatic vec_op_e rand_op(input int n);
    return vec_op_e'(3'({$random(seed)} % n));
  endfunction

  function automatic acc_req_t make_req(input vec_op_e op, input vreg_t vd, input vreg_t vs1,
                                        input vreg_t vs2, input elen_t scalar, input vl_t vl);
    acc_req_t r;
    r.op     = op;
    r.vd     = vd;
    r.vs1    = vs1;
    r.vs2    = vs2;
    r.scalar = scalar;
    r.vl     = vl;
    return r;
  endfunction

  // Register file model where only elements below vl change
  task automatic apply_model(input acc_req_t r);
    elen_t a;
    elen_t b;
    for (int e = 0; e < int'(r.vl); e++) begin
      a = model[r.vs1][e];
      b = model[r.vs2][e];
      case (r.op)
        OP_VADD_VV: model[r.vd][e] = b + a;
        OP_VSUB_VV: model[r.vd][e] = b - a;
        OP_VXOR_VV: model[r.vd][e] = b ^ a;
        OP_VADD_VX: model[r.vd][e] = b + r.scalar;
        OP_VMV_VX:  model[r.vd][e] = r.scalar;
        default:    ;
      endcase
    end
  endtask

  // Sends one request and returns its response
  // lat counts the cycles after acceptance before valid rises
  task automatic run_insn(input acc_req_t req, input bit stall, output acc_resp_t resp,
                          output int lat);
    bit        seen;
    bit        take;
    int        waited;
    acc_resp_t held;
    seen   = 1'b0;
    take   = 1'b0;
    waited = 0;
    lat    = -1;
    held   = '0;
    @(negedge clk_i);
    acc_req_i       = req;
    acc_req_valid_i = 1'b1;
    while (!acc_req_ready_o) @(negedge clk_i);
    // Accepted on the rising edge in between
    @(negedge clk_i);
    acc_req_valid_i = 1'b0;
    while (!take) begin
      if (acc_req_ready_o) begin
        fail_run("Request ready went high before the response was taken");
      end
      if (acc_resp_valid_o) begin
        if (!seen) begin
          seen = 1'b1;
          held = acc_resp_o;
          lat  = waited;
        end else if (acc_resp_o !== held) begin
          fail_run($sformatf("ERROR acc_resp_o changed while stalled 0x%h to 0x%h",
                             held, acc_resp_o));
        end
      end
      acc_resp_ready_i = stall ? (($random(seed) & 1) != 0) : 1'b1;
      take = acc_resp_valid_o && acc_resp_ready_i;
      @(negedge clk_i);
      waited++;
    end
    acc_resp_ready_i = 1'b0;
    resp = held;
  endtask

  task automatic extract_check(input vreg_t vs2, input int idx, input bit stall);
    acc_req_t  req;
    acc_resp_t resp;
    int        lat;
    elen_t     scalar;
    // Upper bits are random since the index wraps at VLMAX
    scalar = elen_t'($random(seed)) * elen_t'(VLMAX) + elen_t'(idx);
    req = make_req(OP_VEXT_XV, rand_reg(), rand_reg(), vs2, scalar, rand_vl());
    run_insn(req, stall, resp, lat);
    // Issue, lane start, lane done and sequencer done each take one cycle
    if (lat != 4) begin
      fail_run($sformatf("Extract response arrived %0d cycles after acceptance instead of 5",
                         lat + 1));
    end
    check_error("acc_resp_o.error", resp.error, 1'b0);
    check_result("acc_resp_o.result", resp.result,
                 model[vs2][int'(scalar % elen_t'(VLMAX))]);
  endtask

  task automatic op_check(input acc_req_t req, input bit stall);
    acc_resp_t resp;
    int        lat;
    run_insn(req, stall, resp, lat);
    if (int'(req.vl) > VLMAX) begin
      check_error("acc_resp_o.error", resp.error, 1'b1);
      check_result("acc_resp_o.result", resp.result, '0);
      if (lat != 0) begin
        fail_run("Error response did not arrive one cycle after acceptance");
      end
    end else begin
      check_error("acc_resp_o.error", resp.error, 1'b0);
      apply_model(req);
    end
  endtask

  task automatic check_vreg(input vreg_t r, input bit stall);
    for (int e = 0; e < VLMAX; e++) begin
      extract_check(r, e, stall);
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    vreg_t vd;
    vl_t   bad_vl;
    seed             = 73552;
    clk_i            = 1'b0;
    reset_i          = 1'b1;
    acc_req_i        = '0;
    acc_req_valid_i  = 1'b0;
    acc_resp_ready_i = 1'b0;
    for (int r = 0; r < NR_VREGS; r++) begin
      for (int e = 0; e < VLMAX; e++) begin
        model[r][e] = '0;
      end
    end
    repeat (3) @(negedge clk_i);
    reset_i = 1'b0;
    @(negedge clk_i);
    if (acc_req_ready_o !== 1'b1 || acc_resp_valid_o !== 1'b0) begin
      fail_run("Handshake outputs are wrong after reset");
    end

    // Registers read back as zero
    repeat (N_RESET_EXT) begin
      extract_check(vreg_t'($random(seed)), int'({$random(seed)} % VLMAX), 1'b0);
    end

    // Full splat and then a partial one over it
    vd = rand_reg();
    op_check(make_req(OP_VMV_VX, vd, rand_reg(), rand_reg(), elen_t'($random(seed)),
                      vl_t'(VLMAX)), 1'b0);
    op_check(make_req(OP_VMV_VX, vd, rand_reg(), rand_reg(), elen_t'($random(seed)),
                      rand_vl()), 1'b0);
    check_vreg(vd, 1'b0);

    repeat (N_STREAM) begin
      vd = rand_reg();
      op_check(make_req(rand_op(4), vd, rand_reg(), rand_reg(), elen_t'($random(seed)),
                        rand_vl()), 1'b0);
      check_vreg(vd, 1'b0);
    end

    // Oversized vl from 33 to 63
    repeat (N_BAD_VL) begin
      vd     = rand_reg();
      bad_vl = vl_t'(VLMAX + 1 + {$random(seed)} % (63 - VLMAX));
      op_check(make_req(rand_op(5), vd, rand_reg(), rand_reg(), elen_t'($random(seed)),
                        bad_vl), 1'b0);
      check_vreg(vd, 1'b0);
    end

    // Mixed traffic with response back-pressure
    repeat (N_STALL) begin
      if (($random(seed) & 1) != 0) begin
        extract_check(rand_reg(), int'({$random(seed)} % VLMAX), 1'b1);
      end else begin
        op_check(make_req(rand_op(5), rand_reg(), rand_reg(), rand_reg(),
                          elen_t'($random(seed)), rand_vl()), 1'b1);
      end
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
logic/vec_pkg.sv
logic/lane_vrf.sv
logic/vec_lane.sv
logic/vec_sequencer.sv
logic/vec_dispatcher.sv
logic/vec_top.sv
tb/tb_vec_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the vector accelerator testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module tb_vec_top -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_vec_top > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
exit 0
